//--- build.f
+incdir+common
common/lite_rd_pkg.sv
axis_to_lite_rd/axis_field_parser.sv
axis_to_lite_rd/axis_field_gen.sv
axis_to_lite_rd/axis_to_lite_rd.sv
hdl/lite_reg_bank.sv
hdl/lite_rd_top.sv
sim/lite_rd_sva.sv
sim/lite_rd_checker.sv
sim/tb_lite_rd.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_lite_rd
FILELIST := build.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_lite_rd.sv
// Testbench for the stream to AXI-lite read subsystem.
// Loads the bank, then plays a table of address packets under back-pressure.
`timescale 1ns/100ps
`include "lite_rd_consts.svh"

module tb_lite_rd;

    localparam int NUM_ROWS  = 16;
    localparam int WAIT_MAX  = 200;  // cycles one input byte may stall.
    localparam int DRAIN_MAX = 3000; // cycles for all owed responses to leave.

    // bp bit 0 randomizes out_tready, bit 1 puts gaps into in_tvalid.
    // for a short packet, extra is the number of field bytes sent.
    typedef struct packed {
        lite_rd_pkg::lite_addr_t addr;
        logic [3:0]              extra;
        logic                    short_pkt;
        logic [1:0]              bp;
        logic                    rewrite;  // new_word goes to the addressed register first.
        lite_rd_pkg::word_t      new_word;
    } stim_row_t;

    logic                  aclk = 1'b0;
    logic                  rst_n = 1'b0;
    lite_rd_pkg::byte_t    in_tdata = '0;
    logic                  in_tvalid = 1'b0;
    logic                  in_tready;
    logic                  in_tlast = 1'b0;
    lite_rd_pkg::byte_t    out_tdata;
    logic                  out_tvalid;
    logic                  out_tready = 1'b1;
    logic                  out_tlast;
    logic                  cfg_we = 1'b0;
    lite_rd_pkg::reg_idx_t cfg_idx = '0;
    lite_rd_pkg::word_t    cfg_wdata = '0;
    int                    err_cnt;          // mismatches seen by the checker.
    int                    resp_cnt;         // full responses seen by the checker.
    integer                seed = 32'h545b2f9f;
    logic [31:0]           rnd_bits = '0;
    logic                  rdy_next = 1'b1;
    logic [1:0]            cur_bp = 2'd0;
    int                    tb_errs = 0;
    int                    full_sent = 0;    // packets that carried a whole field.

    lite_rd_pkg::word_t cfg_tab [`LITE_REG_WORDS] = '{
        32'h0123_4567, 32'h89AB_CDEF, 32'h1122_3344, 32'h5566_7788,
        32'h99AA_BBCC, 32'hDDEE_FF00, 32'h0F1E_2D3C, 32'h4B5A_6978,
        32'h8796_A5B4, 32'hC3D2_E1F0, 32'h1357_9BDF, 32'h2468_ACE0,
        32'hFEDC_BA98, 32'h7654_3210, 32'hA5A5_5A5A, 32'h3C3C_C3C3};

    stim_row_t stim_tab [NUM_ROWS] = '{
        '{32'h0000_0000, 4'd0, 1'b0, 2'd0, 1'b0, 32'h0},           // back to back.
        '{32'h0000_0004, 4'd0, 1'b0, 2'd0, 1'b0, 32'h0},
        '{32'h0000_003C, 4'd2, 1'b0, 2'd0, 1'b0, 32'h0},           // two trailing bytes.
        '{32'h0000_0040, 4'd0, 1'b0, 2'd0, 1'b0, 32'h0},           // bit 6, error word.
        '{32'h8000_0010, 4'd1, 1'b0, 2'd0, 1'b0, 32'h0},           // bit 31, error word.
        '{32'h0000_0008, 4'd2, 1'b1, 2'd0, 1'b0, 32'h0},           // two-byte packet.
        '{32'h0000_0008, 4'd0, 1'b0, 2'd0, 1'b0, 32'h0},
        '{32'h0000_000C, 4'd3, 1'b0, 2'd1, 1'b0, 32'h0},
        '{32'h0000_0010, 4'd0, 1'b0, 2'd1, 1'b0, 32'h0},
        '{32'h0000_0014, 4'd0, 1'b0, 2'd3, 1'b0, 32'h0},
        '{32'h0000_0018, 4'd1, 1'b0, 2'd2, 1'b0, 32'h0},
        '{32'h0000_001C, 4'd1, 1'b1, 2'd2, 1'b0, 32'h0},           // one-byte packet.
        '{32'h0000_001C, 4'd0, 1'b0, 2'd0, 1'b1, 32'hCAFE_0123}, // register 7 rewritten.
        '{32'h0000_0100, 4'd0, 1'b0, 2'd1, 1'b0, 32'h0},           // bit 8, error word.
        '{32'h0000_0020, 4'd5, 1'b0, 2'd3, 1'b0, 32'h0},
        '{32'h0000_001C, 4'd0, 1'b0, 2'd3, 1'b0, 32'h0}};          // still the new value.

    lite_rd_top     lite_rd_top_inst (.*);
    lite_rd_checker lite_rd_checker_inst (.*);

    always #4 aclk = ~aclk;

    // random bits are drawn on the falling edge and used after the next rising one.
    always @(negedge aclk) begin
        rnd_bits = $random(seed);
        rdy_next = cur_bp[0] ? rnd_bits[0] : 1'b1;
    end

    always @(posedge aclk) begin
        #1;
        out_tready = rdy_next;
    end

    task automatic cfg_write(input lite_rd_pkg::reg_idx_t idx, input lite_rd_pkg::word_t data);
        cfg_we    = 1'b1;
        cfg_idx   = idx;
        cfg_wdata = data;
        @(posedge aclk);
        #1;
        cfg_we = 1'b0;
    endtask

    // in_tready does not depend on in_tvalid, so its value after the drive holds to the edge.
    task automatic send_byte(input lite_rd_pkg::byte_t d, input logic last);
        int gaps;
        int waited;
        gaps = 0;
        while (cur_bp[1] && rnd_bits[1] && gaps < 3) begin
            in_tvalid = 1'b0;
            @(posedge aclk);
            #1;
            gaps++;
        end
        in_tdata  = d;
        in_tlast  = last;
        in_tvalid = 1'b1;
        waited = 0;
        while (!in_tready && waited < WAIT_MAX) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (!in_tready) begin
            $display("%0t: input byte %02h was never accepted", $time, d);
            tb_errs++;
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic send_packet(input stim_row_t row);
        lite_rd_pkg::byte_t d;
        int                 nfield;
        int                 total;
        int                 i;
        nfield = row.short_pkt ? int'(row.extra) : `LITE_ADDR_BYTES;
        total  = row.short_pkt ? nfield : nfield + int'(row.extra);
        for (i = 0; i < total; i++) begin
            d = (i < nfield) ? row.addr[31 - 8 * i -: 8] : 8'hA0 + 8'(i); // trailing filler.
            send_byte(d, i == total - 1);
        end
        if (!row.short_pkt) full_sent++;
    endtask

    task automatic wait_drain();
        int waited;
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        waited = 0;
        while (resp_cnt < full_sent && waited < DRAIN_MAX) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (resp_cnt < full_sent) begin
            $display("%0t: timed out with %0d of %0d responses received",
                     $time, resp_cnt, full_sent);
            tb_errs++;
        end
    endtask

    initial begin
        int i;
        repeat (4) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < `LITE_REG_WORDS; i++) begin
            cfg_write(lite_rd_pkg::reg_idx_t'(i), cfg_tab[i]);
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            cur_bp = stim_tab[i].bp;
            if (stim_tab[i].rewrite) begin
                wait_drain(); // reads already in flight still see the old word.
                cfg_write(stim_tab[i].addr[5:2], stim_tab[i].new_word);
            end
            send_packet(stim_tab[i]);
        end
        cur_bp = 2'd0;
        wait_drain();
        repeat (20) @(posedge aclk); // a stray extra response would show up here.
        if (resp_cnt != full_sent) begin
            $display("[FAIL] %0t ns resp_cnt expected %0d actual %0d", $time, full_sent, resp_cnt);
            tb_errs++;
        end
        $display("responses %0d of %0d, checker errors %0d, testbench errors %0d",
                 resp_cnt, full_sent, err_cnt, tb_errs);
        if (err_cnt == 0 && tb_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim/lite_rd_checker.sv
// Scoreboard for the read subsystem. Mirrors the bank from the config writes,
// predicts one word per complete input packet and checks every output beat.
`timescale 1ns/100ps
`include "lite_rd_consts.svh"

module lite_rd_checker (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  lite_rd_pkg::byte_t    in_tdata,
    input  logic                  in_tvalid,
    input  logic                  in_tready,
    input  logic                  in_tlast,
    input  lite_rd_pkg::byte_t    out_tdata,
    input  logic                  out_tvalid,
    input  logic                  out_tready,
    input  logic                  out_tlast,
    input  logic                  cfg_we,
    input  lite_rd_pkg::reg_idx_t cfg_idx,
    input  lite_rd_pkg::word_t    cfg_wdata,
    output int                    err_cnt,
    output int                    resp_cnt
);

    localparam int WORD_BYTES = 4; // bytes in one response packet.

    lite_rd_pkg::word_t      model [`LITE_REG_WORDS]; // copy of the bank.
    lite_rd_pkg::word_t      exp_q [$];               // responses still owed.
    lite_rd_pkg::lite_addr_t fld;                     // field being assembled.
    int                      in_pos;                  // byte index in the input packet.
    int                      out_pos;                 // byte index in the output packet.

    // any address bit above the bank reads as the error pattern.
    function automatic lite_rd_pkg::word_t predict(input lite_rd_pkg::lite_addr_t a);
        if (a[31:6] != '0) return `LITE_ERR_WORD;
        return model[a[5:2]];
    endfunction

    always @(posedge aclk) begin
        lite_rd_pkg::byte_t exp_b;
        logic               exp_l;
        if (!rst_n) begin
            foreach (model[i]) model[i] = '0; // the bank clears on reset.
            exp_q.delete();
            in_pos   = 0;
            out_pos  = 0;
            err_cnt  = 0;
            resp_cnt = 0;
        end else begin
            if (cfg_we) model[cfg_idx] = cfg_wdata;
            if (in_tvalid && in_tready) begin
                if (in_pos < `LITE_ADDR_BYTES) begin
                    fld = {fld[23:0], in_tdata}; // most significant byte comes first.
                    if (in_pos == `LITE_ADDR_BYTES - 1) exp_q.push_back(predict(fld));
                end
                in_pos = in_tlast ? 0 : in_pos + 1; // short packets never reach a push.
            end
            if (out_tvalid && out_tready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: output byte %02h arrived with no response pending",
                             $time, out_tdata);
                    err_cnt++;
                end else begin
                    exp_b = exp_q[0][31 - 8 * out_pos -: 8];
                    exp_l = (out_pos == WORD_BYTES - 1);
                    if (out_tdata !== exp_b) begin
                        $display("[FAIL] %0t ns out_tdata expected %02h actual %02h",
                                 $time, exp_b, out_tdata);
                        err_cnt++;
                    end
                    if (out_tlast !== exp_l) begin
                        $display("[FAIL] %0t ns out_tlast expected %0b actual %0b",
                                 $time, exp_l, out_tlast);
                        err_cnt++;
                    end
                    if (exp_l) begin
                        void'(exp_q.pop_front());
                        resp_cnt++;
                        out_pos = 0;
                    end else begin
                        out_pos++;
                    end
                end
            end
        end
    end

endmodule

//--- sim/lite_rd_sva.sv
// Handshake assertions for the bridge core.
// Bound into the bridge so that its internal parser hand-off is visible.
`timescale 1ns/100ps

module lite_rd_sva (
    input logic                    aclk,
    input logic                    rst_n,
    input logic                    out_tvalid,
    input logic                    out_tready,
    input lite_rd_pkg::byte_t      out_tdata,
    input logic                    arvalid,
    input logic                    arready,
    input lite_rd_pkg::lite_addr_t araddr,
    input logic                    addr_req,
    input logic                    addr_ack
);

    // a stalled output beat keeps its valid and its byte.
    assert property (@(posedge aclk) disable iff (!rst_n)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata))
        else $error("output beat dropped or changed while out_tready was low");

    // the AR address holds for as long as the request is up.
    assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid |-> $stable(araddr))
        else $error("araddr changed while arvalid was high");

    // the AR request only falls after the bank has taken it.
    assert property (@(posedge aclk) disable iff (!rst_n)
        $fell(arvalid) |-> $past(arready))
        else $error("arvalid fell before arready");

    // request stays up until acked, ack stays up until the request falls.
    assert property (@(posedge aclk) disable iff (!rst_n)
        addr_req && !addr_ack |=> addr_req)
        else $error("addr_req fell before addr_ack");
    assert property (@(posedge aclk) disable iff (!rst_n)
        addr_req && addr_ack |=> addr_ack)
        else $error("addr_ack fell while addr_req was still high");

    // no new request until the previous ack is gone.
    assert property (@(posedge aclk) disable iff (!rst_n)
        !addr_req && addr_ack |=> !addr_req)
        else $error("addr_req rose again before addr_ack fell");

endmodule

bind axis_to_lite_rd lite_rd_sva lite_rd_sva_inst (.*);

//--- hdl/lite_rd_top.sv
// Top level of the read subsystem.
// Connects the stream bridge to the local register bank.
`timescale 1ns/100ps

module lite_rd_top (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  lite_rd_pkg::byte_t    in_tdata,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    output lite_rd_pkg::byte_t    out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    input  logic                  cfg_we,
    input  lite_rd_pkg::reg_idx_t cfg_idx,
    input  lite_rd_pkg::word_t    cfg_wdata
);

    // AXI-lite read channel between bridge and bank.
    logic                    arvalid;
    logic                    arready;
    lite_rd_pkg::lite_addr_t araddr;
    logic                    rvalid;
    logic                    rready;
    lite_rd_pkg::word_t      rdata;
    lite_rd_pkg::resp_t      rresp;

    axis_to_lite_rd axis_to_lite_rd_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    lite_reg_bank lite_reg_bank_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .cfg_we    (cfg_we),
        .cfg_idx   (cfg_idx),
        .cfg_wdata (cfg_wdata)
    );

endmodule

//--- hdl/lite_reg_bank.sv
// AXI-lite read slave over a small register array.
// The array is loaded through a single-cycle config write port.
`timescale 1ns/100ps
`include "lite_rd_consts.svh"

module lite_reg_bank (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    arvalid,
    output logic                    arready,
    input  lite_rd_pkg::lite_addr_t araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output lite_rd_pkg::word_t      rdata,
    output lite_rd_pkg::resp_t      rresp,
    input  logic                    cfg_we,
    input  lite_rd_pkg::reg_idx_t   cfg_idx,
    input  lite_rd_pkg::word_t      cfg_wdata
);

    lite_rd_pkg::word_t    regs [`LITE_REG_WORDS];
    lite_rd_pkg::reg_idx_t rd_idx;   // word index from the byte address.
    logic                  out_rng;  // address lies above the bank.

    assign rd_idx  = araddr[5:2];
    assign out_rng = |araddr[31:6];
    assign arready = !rvalid; // a new read is taken only when none is pending.

    // the bank must read as zero after reset.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LITE_REG_WORDS; i++) regs[i] <= '0;
        end else if (cfg_we) begin
            regs[cfg_idx] <= cfg_wdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (arvalid && arready) begin
            rdata <= out_rng ? `LITE_ERR_WORD : regs[rd_idx];
            rresp <= out_rng ? `LITE_RESP_SLVERR : `LITE_RESP_OKAY;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1; // data one cycle after the AR transfer.
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

//--- axis_to_lite_rd/axis_to_lite_rd.sv
// Bridge core from a byte command stream to AXI-lite reads.
// Parser and generator sit on the streams, the read engine sits between them.
`timescale 1ns/100ps

module axis_to_lite_rd (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  lite_rd_pkg::byte_t      in_tdata,
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic                    in_tlast,
    output lite_rd_pkg::byte_t      out_tdata,
    output logic                    out_tvalid,
    input  logic                    out_tready,
    output logic                    out_tlast,
    output logic                    arvalid,
    input  logic                    arready,
    output lite_rd_pkg::lite_addr_t araddr,
    input  logic                    rvalid,
    output logic                    rready,
    input  lite_rd_pkg::word_t      rdata,
    input  lite_rd_pkg::resp_t      rresp
);

    logic                    addr_req;
    logic                    addr_ack;
    lite_rd_pkg::lite_addr_t field_addr;
    logic                    word_req;
    logic                    word_ack;
    lite_rd_pkg::word_t      rd_word;
    lite_rd_pkg::rd_state_t  state;

    axis_field_parser axis_field_parser_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .addr_req   (addr_req),
        .addr_ack   (addr_ack),
        .field_addr (field_addr)
    );

    assign rready = (state == lite_rd_pkg::DATA); // one R beat is expected per read.

    // rdata goes to the generator as returned.
    // The bank already puts the error pattern on an out-of-range read.
    always_ff @(posedge aclk) begin
        if (state == lite_rd_pkg::IDLE && addr_req && !addr_ack) begin
            araddr <= field_addr;
        end
        if (state == lite_rd_pkg::DATA && rvalid) begin
            rd_word <= rdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= lite_rd_pkg::IDLE;
            addr_ack <= 1'b0;
            arvalid  <= 1'b0;
            word_req <= 1'b0;
        end else begin
            // the ack falls as soon as the parser has dropped its request.
            if (addr_ack && !addr_req) addr_ack <= 1'b0;

            case (state)
                lite_rd_pkg::IDLE: begin
                    if (addr_req && !addr_ack) begin
                        addr_ack <= 1'b1;
                        state    <= lite_rd_pkg::ADDR;
                    end
                end
                lite_rd_pkg::ADDR: begin
                    if (!arvalid) begin
                        arvalid <= 1'b1; // one cycle after the address was taken.
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        state   <= lite_rd_pkg::DATA;
                    end
                end
                lite_rd_pkg::DATA: begin
                    if (rvalid) begin
                        word_req <= 1'b1;
                        state    <= lite_rd_pkg::HAND;
                    end
                end
                lite_rd_pkg::HAND: begin
                    // same four-phase order as the parser side.
                    if (word_req && word_ack) begin
                        word_req <= 1'b0;
                    end else if (!word_req && !word_ack) begin
                        state <= lite_rd_pkg::IDLE;
                    end
                end
                default: state <= lite_rd_pkg::IDLE;
            endcase
        end
    end

    axis_field_gen axis_field_gen_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .word_req   (word_req),
        .word_ack   (word_ack),
        .rd_word    (rd_word),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast)
    );

endmodule

//--- axis_to_lite_rd/axis_field_gen.sv
// Output side of the bridge. Takes a read word over a four-phase request
// and sends it as a four-byte packet, most significant byte first.
`timescale 1ns/100ps

module axis_field_gen (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               word_req,
    output logic               word_ack,
    input  lite_rd_pkg::word_t rd_word,
    output lite_rd_pkg::byte_t out_tdata,
    output logic               out_tvalid,
    input  logic               out_tready,
    output logic               out_tlast
);

    lite_rd_pkg::word_t shift_q; // word being sent, current byte at the top.
    logic [1:0]         beat;    // index of the beat on the bus.
    logic               pend;    // word captured, first beat not yet valid.
    logic               capture; // take a new word this cycle.
    logic               beat_ok; // an output beat transfers this cycle.

    // a word is only taken once the previous packet has fully drained.
    assign capture = word_req && !word_ack && !pend && !out_tvalid;
    assign beat_ok = out_tvalid && out_tready;

    assign out_tdata = shift_q[31:24];
    assign out_tlast = (beat == 2'(($bits(lite_rd_pkg::word_t) / 8) - 1));

    // shifting only on accepted beats keeps the byte stable under back-pressure.
    always_ff @(posedge aclk) begin
        if (capture) begin
            shift_q <= rd_word;
        end else if (beat_ok) begin
            shift_q <= shift_q << 8;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            word_ack   <= 1'b0;
            pend       <= 1'b0;
            out_tvalid <= 1'b0;
            beat       <= '0;
        end else begin
            // ack at capture, so the engine may fetch the next word meanwhile.
            if (capture) begin
                word_ack <= 1'b1;
                pend     <= 1'b1;
            end else if (word_ack && !word_req) begin
                word_ack <= 1'b0;
            end

            if (pend) begin
                pend       <= 1'b0;
                out_tvalid <= 1'b1; // first beat one cycle after capture.
            end

            if (beat_ok) begin
                if (out_tlast) begin
                    out_tvalid <= 1'b0;
                    beat       <= '0;
                end else begin
                    beat <= beat + 2'd1;
                end
            end
        end
    end

endmodule

//--- axis_to_lite_rd/axis_field_parser.sv
// Input side of the bridge. Collects the address field from the byte stream
// and hands it to the read engine through a four-phase request.
`timescale 1ns/100ps
`include "lite_rd_consts.svh"

module axis_field_parser (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  lite_rd_pkg::byte_t      in_tdata,
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic                    in_tlast,
    output logic                    addr_req,
    input  logic                    addr_ack,
    output lite_rd_pkg::lite_addr_t field_addr
);

    lite_rd_pkg::parse_state_t state;
    logic [2:0]                byte_cnt;  // field bytes taken so far.
    logic                      pkt_ended; // the fourth field byte carried tlast.
    logic                      beat_ok;   // an input beat transfers this cycle.

    // the stream only stalls while a finished address waits for the engine.
    assign in_tready = (state != lite_rd_pkg::HOLD);
    assign beat_ok   = in_tvalid && in_tready;

    // field bytes arrive most significant first, so shift in from the bottom.
    always_ff @(posedge aclk) begin
        if (beat_ok && state == lite_rd_pkg::COLLECT) begin
            field_addr <= {field_addr[23:0], in_tdata};
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= lite_rd_pkg::COLLECT;
            byte_cnt  <= '0;
            pkt_ended <= 1'b0;
            addr_req  <= 1'b0;
        end else begin
            case (state)
                lite_rd_pkg::COLLECT: begin
                    if (beat_ok) begin
                        if (byte_cnt == 3'(`LITE_ADDR_BYTES - 1)) begin
                            // the last field byte, request goes up right away.
                            byte_cnt  <= '0;
                            addr_req  <= 1'b1;
                            pkt_ended <= in_tlast;
                            state     <= lite_rd_pkg::HOLD;
                        end else if (in_tlast) begin
                            byte_cnt <= '0; // short packet, the partial field is dropped.
                        end else begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end
                    end
                end
                lite_rd_pkg::HOLD: begin
                    // drop the request on ack, then wait for the ack to fall.
                    if (addr_req && addr_ack) begin
                        addr_req <= 1'b0;
                    end else if (!addr_req && !addr_ack) begin
                        state <= pkt_ended ? lite_rd_pkg::COLLECT : lite_rd_pkg::DISCARD;
                    end
                end
                lite_rd_pkg::DISCARD: begin
                    if (beat_ok && in_tlast) begin
                        state <= lite_rd_pkg::COLLECT; // trailing bytes gone, next packet.
                    end
                end
                default: state <= lite_rd_pkg::COLLECT;
            endcase
        end
    end

endmodule

//--- common/lite_rd_pkg.sv
// Types for the stream to AXI-lite read subsystem.
// Vector typedefs for the meaningful widths and the two FSM state enums.
package lite_rd_pkg;

    typedef logic [7:0] byte_t;       // one beat on either byte stream.
    typedef logic [31:0] word_t;      // one register word.
    typedef logic [31:0] lite_addr_t; // byte address on the AXI-lite bus.
    typedef logic [3:0] reg_idx_t;    // word index into the bank.
    typedef logic [1:0] resp_t;       // AXI-lite read response.

    // parser FSM. HOLD keeps the finished address until the engine takes it.
    typedef enum logic [1:0] {
        COLLECT = 2'd0, // shifting in field bytes.
        HOLD    = 2'd1, // address complete, input stalled.
        DISCARD = 2'd2  // dropping the rest of the packet.
    } parse_state_t;

    // read engine FSM, one read at a time.
    typedef enum logic [1:0] {
        IDLE = 2'd0, // waiting for an address from the parser.
        ADDR = 2'd1, // AR channel in progress.
        DATA = 2'd2, // waiting for the R beat.
        HAND = 2'd3  // handing the word to the generator.
    } rd_state_t;

endpackage

//--- common/lite_rd_consts.svh
// Shared constants for the stream to AXI-lite read subsystem.
// Holds the field length, the bank depth, the error pattern and the response codes.
`ifndef LITE_RD_CONSTS_SVH
`define LITE_RD_CONSTS_SVH

// bytes in the address field at the head of each input packet.
`define LITE_ADDR_BYTES 4

// number of 32-bit words in the local register bank.
`define LITE_REG_WORDS 16

// pattern returned for any read outside the bank.
`define LITE_ERR_WORD 32'hDEAD_BEEF

// AXI-lite response codes, as the bus defines them.
`define LITE_RESP_OKAY 2'b00
`define LITE_RESP_SLVERR 2'b10

`endif
